//--- logic/bus_map_pkg.sv
`default_nettype none

package bus_map_pkg;

	////////////////////////////////////////////////////////////
	// region codes and the shared video address
	////////////////////////////////////////////////////////////

	// what one cpu address selects
	typedef enum logic [2:0] {
		REG_NONE,
		REG_SCROLL0,
		REG_SCROLL1,
		REG_OBJECT,
		REG_LATCH,
		REG_BACKCOLOR,
		REG_IRQ_ACK
	} region_e;

	// same 13 bits, seen as a ram offset or as a latch select
	typedef union packed {
		logic [12:0] ram;
		struct packed {
			logic [9:0] unused;
			logic       layer;
			logic [1:0] index;
		} latch;
	} vid_addr_u;

	// latch register index
	localparam logic [1:0] LATCH_SCROLL_X_LO = 2'd0;
	localparam logic [1:0] LATCH_SCROLL_X_HI = 2'd1;
	localparam logic [1:0] LATCH_SCROLL_Y    = 2'd2;

	////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////

	// window sizes as low address bits ignored by the compare
	localparam int unsigned RAM_WIN_BITS   = 13;
	localparam int unsigned LATCH_WIN_BITS = 11;
	localparam int unsigned IO_WIN_BITS    = 10;

	// ram windows, same on both cpus
	localparam logic [15:0] SCROLL0_BASE = 16'h0000;
	localparam logic [15:0] SCROLL1_BASE = 16'h2000;
	localparam logic [15:0] OBJECT_BASE  = 16'h4000;

	// master io
	localparam logic [15:0] M_LATCH_BASE     = 16'h8800;
	localparam logic [15:0] M_IRQ_ACK_BASE   = 16'h9000;
	localparam logic [15:0] M_BACKCOLOR_BASE = 16'h9400;

	// sub io, no backcolor here
	localparam logic [15:0] S_LATCH_BASE   = 16'h6000;
	localparam logic [15:0] S_IRQ_ACK_BASE = 16'h8000;

	// true when addr falls in the aligned window at base
	function automatic logic in_window(input logic [15:0] addr, input logic [15:0] base,
			input int unsigned win_bits);
		return (addr >> win_bits) == (base >> win_bits);
	endfunction

endpackage

`default_nettype wire

//--- logic/video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

	////////////////////////////////////////////////////////////
	// pixel clock
	////////////////////////////////////////////////////////////

	// 48 MHz down to 6 MHz dot clock
	localparam int PIX_DIV = 8;

	////////////////////////////////////////////////////////////
	// default raster, counted in pixels and lines
	////////////////////////////////////////////////////////////

	localparam int H_TOTAL     = 384;
	localparam int H_ACTIVE    = 288;
	localparam int HSYNC_START = 304;
	localparam int HSYNC_LEN   = 32;

	localparam int V_TOTAL     = 264;
	localparam int V_ACTIVE    = 224;
	localparam int VSYNC_START = 240;
	localparam int VSYNC_LEN   = 8;

	// tile layer map, one byte per 8x8 tile
	localparam int TILE_COLS = 64;
	localparam int TILE_ROWS = 64;

endpackage

`default_nettype wire

//--- logic/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing #(
	parameter int H_TOTAL     = video_timing_pkg::H_TOTAL,
	parameter int H_ACTIVE    = video_timing_pkg::H_ACTIVE,
	parameter int HSYNC_START = video_timing_pkg::HSYNC_START,
	parameter int HSYNC_LEN   = video_timing_pkg::HSYNC_LEN,
	parameter int V_TOTAL     = video_timing_pkg::V_TOTAL,
	parameter int V_ACTIVE    = video_timing_pkg::V_ACTIVE,
	parameter int VSYNC_START = video_timing_pkg::VSYNC_START,
	parameter int VSYNC_LEN   = video_timing_pkg::VSYNC_LEN
) (
	input  wire        clk_48m,
	input  wire        rst,
	output logic       pix_en,
	output logic [1:0] phase,
	output logic [8:0] hcount,
	output logic [8:0] vcount,
	output logic       hblank,
	output logic       vblank,
	output logic       hsync,
	output logic       vsync,
	output logic       vblank_start
);
	import video_timing_pkg::*;

	localparam int DIV_BITS = $clog2(PIX_DIV);

	logic [DIV_BITS-1:0] div_cnt;
	logic                h_wrap;
	logic [8:0]          h_next;
	logic [8:0]          v_next;
	logic                vblank_next;

	// dot clock divider
	always_ff @(posedge clk_48m) begin
		if (rst || div_cnt == DIV_BITS'(PIX_DIV - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign pix_en = (div_cnt == DIV_BITS'(PIX_DIV - 1));

	// counter values after the coming pix_en
	always_comb begin
		h_wrap = (hcount == 9'(H_TOTAL - 1));
		h_next = h_wrap ? 9'd0 : hcount + 9'd1;
		if (!h_wrap) begin
			v_next = vcount;
		end else if (vcount == 9'(V_TOTAL - 1)) begin
			v_next = 9'd0;
		end else begin
			v_next = vcount + 9'd1;
		end
		vblank_next = (v_next >= 9'(V_ACTIVE));
	end

	////////////////////////////////////////////////////////////
	// raster state, all steps on pix_en
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (rst) begin
			phase        <= 2'd0;
			hcount       <= 9'd0;
			vcount       <= 9'd0;
			hblank       <= 1'b0;
			vblank       <= 1'b0;
			hsync        <= 1'b0;
			vsync        <= 1'b0;
			vblank_start <= 1'b0;
		end else begin
			// single clock as vblank goes high
			vblank_start <= pix_en && vblank_next && !vblank;
			if (pix_en) begin
				// 1H and 2H bus phases
				phase  <= phase + 2'd1;
				hcount <= h_next;
				vcount <= v_next;
				// levels follow the new counter values
				hblank <= (h_next >= 9'(H_ACTIVE));
				vblank <= vblank_next;
				hsync  <= (h_next >= 9'(HSYNC_START)) &&
					(h_next < 9'(HSYNC_START + HSYNC_LEN));
				vsync  <= (v_next >= 9'(VSYNC_START)) &&
					(v_next < 9'(VSYNC_START + VSYNC_LEN));
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/master_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module master_decoder (
	input  wire                  clk_48m,
	input  wire                  rst,
	input  wire [15:0]           addr,
	input  wire                  we,
	input  wire                  e,
	input  wire                  vblank_start,
	output bus_map_pkg::region_e region,
	output logic                 backcolor_wr,
	output logic                 irq
);
	import bus_map_pkg::*;

	logic irq_ack;

	////////////////////////////////////////////////////////////
	// master address map
	////////////////////////////////////////////////////////////

	always_comb begin
		if (in_window(addr, SCROLL0_BASE, RAM_WIN_BITS)) begin
			region = REG_SCROLL0;
		end else if (in_window(addr, SCROLL1_BASE, RAM_WIN_BITS)) begin
			region = REG_SCROLL1;
		end else if (in_window(addr, OBJECT_BASE, RAM_WIN_BITS)) begin
			region = REG_OBJECT;
		end else if (in_window(addr, M_LATCH_BASE, LATCH_WIN_BITS)) begin
			region = REG_LATCH;
		end else if (in_window(addr, M_IRQ_ACK_BASE, IO_WIN_BITS)) begin
			region = REG_IRQ_ACK;
		end else if (in_window(addr, M_BACKCOLOR_BASE, IO_WIN_BITS)) begin
			region = REG_BACKCOLOR;
		end else begin
			// rom space and holes
			region = REG_NONE;
		end
	end

	// strobes qualified by the end of the access
	assign backcolor_wr = e && we && (region == REG_BACKCOLOR);
	assign irq_ack      = e && we && (region == REG_IRQ_ACK);

	// vblank irq, ack beats a new vblank
	always_ff @(posedge clk_48m) begin
		if (rst || irq_ack) begin
			irq <= 1'b0;
		end else if (vblank_start) begin
			irq <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/sub_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module sub_decoder (
	input  wire                  clk_48m,
	input  wire                  rst,
	input  wire [15:0]           addr,
	input  wire                  we,
	input  wire                  e,
	input  wire                  vblank_start,
	output bus_map_pkg::region_e region,
	output logic                 irq
);
	import bus_map_pkg::*;

	logic irq_ack;

	// sub map, own latch and ack windows
	always_comb begin
		if (in_window(addr, SCROLL0_BASE, RAM_WIN_BITS)) begin
			region = REG_SCROLL0;
		end else if (in_window(addr, SCROLL1_BASE, RAM_WIN_BITS)) begin
			region = REG_SCROLL1;
		end else if (in_window(addr, OBJECT_BASE, RAM_WIN_BITS)) begin
			region = REG_OBJECT;
		end else if (in_window(addr, S_LATCH_BASE, LATCH_WIN_BITS)) begin
			region = REG_LATCH;
		end else if (in_window(addr, S_IRQ_ACK_BASE, IO_WIN_BITS)) begin
			region = REG_IRQ_ACK;
		end else begin
			region = REG_NONE;
		end
	end

	// ack write seen on the e strobe
	assign irq_ack = e && we && (region == REG_IRQ_ACK);

	// sub vblank irq
	always_ff @(posedge clk_48m) begin
		if (rst || irq_ack) begin
			irq <= 1'b0;
		end else if (vblank_start) begin
			irq <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/bus_mux.sv
`timescale 1ns/1ns
`default_nettype none

module bus_mux (
	input  wire                    clk_48m,
	input  wire                    rst,
	input  wire                    pix_en,
	input  wire [1:0]              phase,
	input  wire [15:0]             m_addr,
	input  wire [7:0]              m_wdata,
	input  wire                    m_we,
	input  var bus_map_pkg::region_e m_region,
	input  wire [15:0]             s_addr,
	input  wire [7:0]              s_wdata,
	input  wire                    s_we,
	input  var bus_map_pkg::region_e s_region,
	input  wire [7:0]              vid_rdata,
	output bus_map_pkg::vid_addr_u vid_addr,
	output logic [7:0]             vid_wdata,
	output logic                   vid_we,
	output bus_map_pkg::region_e   vid_region,
	output logic [7:0]             m_rdata,
	output logic                   m_e,
	output logic [7:0]             s_rdata,
	output logic                   s_e
);
	import bus_map_pkg::*;

	logic m_owner;

	// phase bit 1 low is the master slot
	assign m_owner = !phase[1];

	// one clock strobe at the end of each slot
	assign m_e = !rst && pix_en && (phase == 2'd1);
	assign s_e = !rst && pix_en && (phase == 2'd3);

	always_comb begin
		if (m_owner) begin
			vid_addr.ram = m_addr[12:0];
			vid_wdata    = m_wdata;
			vid_region   = m_region;
		end else begin
			vid_addr.ram = s_addr[12:0];
			vid_wdata    = s_wdata;
			vid_region   = s_region;
		end
	end

	assign vid_we = (m_e && m_we) || (s_e && s_we);

	// read data captured as each slot ends
	// non-ram regions read as FF
	always_ff @(posedge clk_48m) begin
		if (rst) begin
			m_rdata <= 8'h00;
			s_rdata <= 8'h00;
		end else begin
			if (m_e) begin
				case (m_region)
					REG_SCROLL0, REG_SCROLL1, REG_OBJECT: m_rdata <= vid_rdata;
					default:                              m_rdata <= 8'hFF;
				endcase
			end
			if (s_e) begin
				case (s_region)
					REG_SCROLL0, REG_SCROLL1, REG_OBJECT: s_rdata <= vid_rdata;
					default:                              s_rdata <= 8'hFF;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/video_ram.sv
`timescale 1ns/1ns
`default_nettype none

module video_ram (
	input  wire                      clk_48m,
	input  wire                      rst,
	input  wire                      pix_en,
	input  var bus_map_pkg::vid_addr_u vid_addr,
	input  wire [7:0]                vid_wdata,
	input  wire                      vid_we,
	input  var bus_map_pkg::region_e vid_region,
	input  wire                      backcolor_wr,
	input  wire [8:0]                hcount,
	input  wire [8:0]                vcount,
	input  wire                      hblank_raw,
	input  wire                      vblank_raw,
	output logic [7:0]               vid_rdata,
	output logic [7:0]               dot,
	output logic                     hblank,
	output logic                     vblank
);
	import bus_map_pkg::*;
	import video_timing_pkg::*;

	localparam int COL_BITS   = $clog2(TILE_COLS);
	localparam int ROW_BITS   = $clog2(TILE_ROWS);
	localparam int MAP_BITS   = COL_BITS + ROW_BITS;
	localparam int MAP_BYTES  = TILE_COLS * TILE_ROWS;
	localparam int OBJ_BYTES  = 8192;
	// 8x8 dots per tile
	localparam int TILE_SHIFT = 3;

	logic [7:0]          scroll0_mem [MAP_BYTES];
	logic [7:0]          scroll1_mem [MAP_BYTES];
	logic [7:0]          object_mem [OBJ_BYTES];
	logic [8:0]          scroll_x [2];
	logic [7:0]          scroll_y [2];
	logic [7:0]          backcolor;
	logic [9:0]          x_sum [2];
	logic [9:0]          y_sum [2];
	logic [MAP_BITS-1:0] tile_off [2];
	logic [MAP_BITS-1:0] map_off [2];
	logic [7:0]          l0_byte;
	logic [7:0]          l1_byte;
	logic [7:0]          pick;
	logic [1:0]          hb_pipe;
	logic [1:0]          vb_pipe;

	////////////////////////////////////////////////////////////
	// cpu port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (vid_we) begin
			case (vid_region)
				REG_SCROLL0: scroll0_mem[vid_addr.ram[MAP_BITS-1:0]] <= vid_wdata;
				REG_SCROLL1: scroll1_mem[vid_addr.ram[MAP_BITS-1:0]] <= vid_wdata;
				REG_OBJECT:  object_mem[vid_addr.ram] <= vid_wdata;
				default: ;
			endcase
		end
	end

	// only ram regions give data back
	always_comb begin
		case (vid_region)
			REG_SCROLL0: vid_rdata = scroll0_mem[vid_addr.ram[MAP_BITS-1:0]];
			REG_SCROLL1: vid_rdata = scroll1_mem[vid_addr.ram[MAP_BITS-1:0]];
			REG_OBJECT:  vid_rdata = object_mem[vid_addr.ram];
			default:     vid_rdata = 8'h00;
		endcase
	end

	// scroll latches and background colour
	always_ff @(posedge clk_48m) begin
		if (rst) begin
			scroll_x  <= '{default: '0};
			scroll_y  <= '{default: '0};
			backcolor <= 8'h00;
		end else begin
			if (vid_we && vid_region == REG_LATCH) begin
				case (vid_addr.latch.index)
					LATCH_SCROLL_X_LO: scroll_x[vid_addr.latch.layer][7:0] <= vid_wdata;
					LATCH_SCROLL_X_HI: scroll_x[vid_addr.latch.layer][8] <= vid_wdata[0];
					LATCH_SCROLL_Y:    scroll_y[vid_addr.latch.layer] <= vid_wdata;
					default: ;
				endcase
			end
			if (backcolor_wr) begin
				backcolor <= vid_wdata;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// dot fetch, two pixel pipeline
	////////////////////////////////////////////////////////////

	// scrolled tile offset per layer
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			x_sum[i]    = {1'b0, hcount} + {1'b0, scroll_x[i]};
			y_sum[i]    = {1'b0, vcount} + {2'b00, scroll_y[i]};
			tile_off[i] = {y_sum[i][TILE_SHIFT +: ROW_BITS], x_sum[i][TILE_SHIFT +: COL_BITS]};
		end
	end

	// stage 1 holds the offsets
	always_ff @(posedge clk_48m) begin
		if (pix_en) begin
			map_off <= tile_off;
		end
	end

	// layer0 over layer1 over background
	assign l0_byte = scroll0_mem[map_off[0]];
	assign l1_byte = scroll1_mem[map_off[1]];
	assign pick = (l0_byte != 8'h00) ? l0_byte : (l1_byte != 8'h00) ? l1_byte : backcolor;

	// stage 2 dot, blanks ride alongside
	always_ff @(posedge clk_48m) begin
		if (rst) begin
			hb_pipe <= 2'b00;
			vb_pipe <= 2'b00;
			dot     <= 8'h00;
		end else if (pix_en) begin
			hb_pipe <= {hb_pipe[0], hblank_raw};
			vb_pipe <= {vb_pipe[0], vblank_raw};
			dot     <= (hb_pipe[0] || vb_pipe[0]) ? 8'h00 : pick;
		end
	end

	assign hblank = hb_pipe[1];
	assign vblank = vb_pipe[1];

endmodule

`default_nettype wire

//--- logic/system86.sv
`timescale 1ns/1ns
`default_nettype none

module system86 #(
	parameter int H_TOTAL     = video_timing_pkg::H_TOTAL,
	parameter int H_ACTIVE    = video_timing_pkg::H_ACTIVE,
	parameter int HSYNC_START = video_timing_pkg::HSYNC_START,
	parameter int HSYNC_LEN   = video_timing_pkg::HSYNC_LEN,
	parameter int V_TOTAL     = video_timing_pkg::V_TOTAL,
	parameter int V_ACTIVE    = video_timing_pkg::V_ACTIVE,
	parameter int VSYNC_START = video_timing_pkg::VSYNC_START,
	parameter int VSYNC_LEN   = video_timing_pkg::VSYNC_LEN
) (
	input  wire        clk_48m,
	input  wire        rst,
	input  wire [15:0] m_addr,
	input  wire [7:0]  m_wdata,
	input  wire        m_we,
	input  wire [15:0] s_addr,
	input  wire [7:0]  s_wdata,
	input  wire        s_we,
	output wire [7:0]  m_rdata,
	output wire        m_e,
	output wire        m_irq,
	output wire [7:0]  s_rdata,
	output wire        s_e,
	output wire        s_irq,
	output wire [7:0]  dot,
	output wire        hsync,
	output wire        vsync,
	output wire        hblank,
	output wire        vblank
);
	import bus_map_pkg::*;

	// raster and bus phase
	logic       pix_en;
	logic [1:0] phase;
	logic [8:0] hcount;
	logic [8:0] vcount;
	logic       hblank_raw;
	logic       vblank_raw;
	logic       vblank_start;

	// decoders to bus
	region_e    m_region;
	region_e    s_region;
	logic       backcolor_wr;

	// shared video bus
	vid_addr_u  vid_addr;
	logic [7:0] vid_wdata;
	logic       vid_we;
	region_e    vid_region;
	logic [7:0] vid_rdata;

	video_timing #(
		.H_TOTAL    (H_TOTAL),
		.H_ACTIVE   (H_ACTIVE),
		.HSYNC_START(HSYNC_START),
		.HSYNC_LEN  (HSYNC_LEN),
		.V_TOTAL    (V_TOTAL),
		.V_ACTIVE   (V_ACTIVE),
		.VSYNC_START(VSYNC_START),
		.VSYNC_LEN  (VSYNC_LEN)
	) timing_i (
		.clk_48m     (clk_48m),
		.rst         (rst),
		.pix_en      (pix_en),
		.phase       (phase),
		.hcount      (hcount),
		.vcount      (vcount),
		.hblank      (hblank_raw),
		.vblank      (vblank_raw),
		.hsync       (hsync),
		.vsync       (vsync),
		.vblank_start(vblank_start)
	);

	master_decoder master_dec_i (
		.clk_48m     (clk_48m),
		.rst         (rst),
		.addr        (m_addr),
		.we          (m_we),
		.e           (m_e),
		.vblank_start(vblank_start),
		.region      (m_region),
		.backcolor_wr(backcolor_wr),
		.irq         (m_irq)
	);

	sub_decoder sub_dec_i (
		.clk_48m     (clk_48m),
		.rst         (rst),
		.addr        (s_addr),
		.we          (s_we),
		.e           (s_e),
		.vblank_start(vblank_start),
		.region      (s_region),
		.irq         (s_irq)
	);

	bus_mux bus_mux_i (
		.clk_48m   (clk_48m),
		.rst       (rst),
		.pix_en    (pix_en),
		.phase     (phase),
		.m_addr    (m_addr),
		.m_wdata   (m_wdata),
		.m_we      (m_we),
		.m_region  (m_region),
		.s_addr    (s_addr),
		.s_wdata   (s_wdata),
		.s_we      (s_we),
		.s_region  (s_region),
		.vid_rdata (vid_rdata),
		.vid_addr  (vid_addr),
		.vid_wdata (vid_wdata),
		.vid_we    (vid_we),
		.vid_region(vid_region),
		.m_rdata   (m_rdata),
		.m_e       (m_e),
		.s_rdata   (s_rdata),
		.s_e       (s_e)
	);

	video_ram video_ram_i (
		.clk_48m     (clk_48m),
		.rst         (rst),
		.pix_en      (pix_en),
		.vid_addr    (vid_addr),
		.vid_wdata   (vid_wdata),
		.vid_we      (vid_we),
		.vid_region  (vid_region),
		.backcolor_wr(backcolor_wr),
		.hcount      (hcount),
		.vcount      (vcount),
		.hblank_raw  (hblank_raw),
		.vblank_raw  (vblank_raw),
		.vid_rdata   (vid_rdata),
		.dot         (dot),
		.hblank      (hblank),
		.vblank      (vblank)
	);

endmodule

`default_nettype wire

//--- tb/system86_tb.sv
`timescale 1ns/1ns
`default_nettype none

module system86_tb;
	import video_timing_pkg::*;

	// small raster for simulation
	localparam int TB_H_TOTAL     = 64;
	localparam int TB_H_ACTIVE    = 48;
	localparam int TB_HSYNC_START = 52;
	localparam int TB_HSYNC_LEN   = 4;
	localparam int TB_V_TOTAL     = 40;
	localparam int TB_V_ACTIVE    = 32;
	localparam int TB_VSYNC_START = 34;
	localparam int TB_VSYNC_LEN   = 2;

	localparam int LINE_CLKS  = TB_H_TOTAL * PIX_DIV;
	localparam int FRAME_CLKS = TB_V_TOTAL * LINE_CLKS;
	localparam int CYCLE_LIMIT = 12 * FRAME_CLKS;
	localparam int MAP_BYTES  = TILE_COLS * TILE_ROWS;
	// idle cpu address is unmapped on both cpus
	localparam logic [15:0] IDLE_ADDR = 16'hA000;

	logic        clk_48m;
	logic        rst;
	logic [15:0] m_addr;
	logic [7:0]  m_wdata;
	logic        m_we;
	logic [15:0] s_addr;
	logic [7:0]  s_wdata;
	logic        s_we;
	wire  [7:0]  m_rdata;
	wire         m_e;
	wire         m_irq;
	wire  [7:0]  s_rdata;
	wire         s_e;
	wire         s_irq;
	wire  [7:0]  dot;
	wire         hsync;
	wire         vsync;
	wire         hblank;
	wire         vblank;

	// shadow of the video state
	logic [7:0] l0_shadow [MAP_BYTES];
	logic [7:0] l1_shadow [MAP_BYTES];
	logic [8:0] sx [2];
	logic [7:0] sy [2];
	logic [7:0] bc;

	int error_count = 0;
	int cycles = 0;
	// raster and dot monitor state
	longint tick;
	longint hs_rise;
	longint vs_rise;
	longint hb_fall;
	bit     seen_hs;
	bit     seen_vs;
	bit     seen_hb;
	logic   hs_prev;
	logic   vs_prev;
	logic   hb_prev;
	logic   vb_prev;
	int     line_clk;
	int     line_v;
	bit     dot_arm;
	bit     dot_live;
	int     dot_checks;

	system86 #(
		.H_TOTAL    (TB_H_TOTAL),
		.H_ACTIVE   (TB_H_ACTIVE),
		.HSYNC_START(TB_HSYNC_START),
		.HSYNC_LEN  (TB_HSYNC_LEN),
		.V_TOTAL    (TB_V_TOTAL),
		.V_ACTIVE   (TB_V_ACTIVE),
		.VSYNC_START(TB_VSYNC_START),
		.VSYNC_LEN  (TB_VSYNC_LEN)
	) dut_i (
		.clk_48m(clk_48m),
		.rst    (rst),
		.m_addr (m_addr),
		.m_wdata(m_wdata),
		.m_we   (m_we),
		.s_addr (s_addr),
		.s_wdata(s_wdata),
		.s_we   (s_we),
		.m_rdata(m_rdata),
		.m_e    (m_e),
		.m_irq  (m_irq),
		.s_rdata(s_rdata),
		.s_e    (s_e),
		.s_irq  (s_irq),
		.dot    (dot),
		.hsync  (hsync),
		.vsync  (vsync),
		.hblank (hblank),
		.vblank (vblank)
	);

	initial begin
		clk_48m = 1'b0;
		forever #20 clk_48m = ~clk_48m;
	end

	task automatic fail_now(input string msg);
		error_count++;
		$display("error %0t: %s", $time, msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// run length guard
	always @(posedge clk_48m) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped: cycle limit of %0d clocks reached", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// strobe and blank properties
	////////////////////////////////////////////////////////////

	assert property (@(posedge clk_48m) disable iff (rst) m_e |=> !m_e)
		else fail_now("m_e high for more than one clock");
	assert property (@(posedge clk_48m) disable iff (rst) s_e |=> !s_e)
		else fail_now("s_e high for more than one clock");
	assert property (@(posedge clk_48m) disable iff (rst) !(m_e && s_e))
		else fail_now("m_e and s_e in the same cycle");
	assert property (@(posedge clk_48m) disable iff (rst) (hblank || vblank) |-> dot == 8'h00)
		else fail_now("dot not zero during blank");

	// dot from the layer rule
	function automatic logic [7:0] expected_dot(input int h, input int v);
		int off0;
		int off1;
		off0 = (((v + sy[0]) / 8) % TILE_ROWS) * TILE_COLS + ((h + sx[0]) / 8) % TILE_COLS;
		off1 = (((v + sy[1]) / 8) % TILE_ROWS) * TILE_COLS + ((h + sx[1]) / 8) % TILE_COLS;
		if (l0_shadow[off0] != 8'h00) begin
			return l0_shadow[off0];
		end else if (l1_shadow[off1] != 8'h00) begin
			return l1_shadow[off1];
		end
		return bc;
	endfunction

	////////////////////////////////////////////////////////////
	// raster and dot monitor sampled mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk_48m) begin
		if (rst) begin
			tick     = 0;
			seen_hs  = 0;
			seen_vs  = 0;
			seen_hb  = 0;
			hs_prev  = 1'b0;
			vs_prev  = 1'b0;
			hb_prev  = 1'b0;
			vb_prev  = 1'b0;
			line_clk = 0;
			line_v   = 0;
			dot_live = 0;
		end else begin
			tick++;
			// hsync period and width
			if (hsync && !hs_prev) begin
				if (seen_hs)
					assert (tick - hs_rise == LINE_CLKS)
						else fail_now($sformatf("hsync period %0d", tick - hs_rise));
				seen_hs = 1;
				hs_rise = tick;
			end
			if (!hsync && hs_prev && seen_hs)
				assert (tick - hs_rise == TB_HSYNC_LEN * PIX_DIV)
					else fail_now($sformatf("hsync width %0d", tick - hs_rise));
			if (vsync && !vs_prev) begin
				if (seen_vs)
					assert (tick - vs_rise == FRAME_CLKS)
						else fail_now($sformatf("vsync period %0d", tick - vs_rise));
				seen_vs = 1;
				vs_rise = tick;
			end
			// active part of a line
			if (hblank && !hb_prev && seen_hb)
				assert (tick - hb_fall == TB_H_ACTIVE * PIX_DIV)
					else fail_now($sformatf("hblank low for %0d clocks", tick - hb_fall));
			// new visible line
			if (!hblank && hb_prev) begin
				seen_hb  = 1;
				hb_fall  = tick;
				line_clk = 0;
				if (!vblank && vb_prev) begin
					line_v = 0;
				end else if (!vblank) begin
					line_v++;
				end
			end
			if (!vblank && vb_prev && dot_arm)
				dot_live = 1;
			if (!dot_arm)
				dot_live = 0;
			// mid pixel compare
			if (dot_live && !hblank && !vblank && line_clk % PIX_DIV == PIX_DIV / 2) begin
				assert (dot == expected_dot(line_clk / PIX_DIV, line_v))
					else fail_now($sformatf("dot %02h at h %0d v %0d, want %02h", dot,
						line_clk / PIX_DIV, line_v, expected_dot(line_clk / PIX_DIV, line_v)));
				dot_checks++;
			end
			if (!hblank)
				line_clk++;
			hs_prev = hsync;
			vs_prev = vsync;
			hb_prev = hblank;
			vb_prev = vblank;
		end
	end

	////////////////////////////////////////////////////////////
	// cpu models
	////////////////////////////////////////////////////////////

	task automatic master_access(input logic [15:0] a, input logic [7:0] d, input logic w,
			output logic [7:0] rd);
		// start only while e is low
		do begin
			@(posedge clk_48m);
			#2;
		end while (m_e);
		m_addr  = a;
		m_wdata = d;
		m_we    = w;
		do @(negedge clk_48m); while (!m_e);
		@(posedge clk_48m);
		#2;
		// read data is latched as e falls
		rd     = m_rdata;
		m_addr = IDLE_ADDR;
		m_we   = 1'b0;
	endtask

	task automatic sub_access(input logic [15:0] a, input logic [7:0] d, input logic w,
			output logic [7:0] rd);
		do begin
			@(posedge clk_48m);
			#2;
		end while (s_e);
		s_addr  = a;
		s_wdata = d;
		s_we    = w;
		do @(negedge clk_48m); while (!s_e);
		@(posedge clk_48m);
		#2;
		rd     = s_rdata;
		s_addr = IDLE_ADDR;
		s_we   = 1'b0;
	endtask

	task automatic expect_byte(input logic [7:0] got, input logic [7:0] want, input string what);
		assert (got == want)
			else fail_now($sformatf("%s read %02h, want %02h", what, got, want));
	endtask

	// write the visible tiles of one layer with the column or zero
	task automatic fill_window(input int layer, input bit clear);
		int hs [7];
		int vs [5];
		int off;
		int col;
		logic [7:0] val;
		logic [7:0] rd;
		hs = '{0, 8, 16, 24, 32, 40, 47};
		vs = '{0, 8, 16, 24, 31};
		foreach (vs[j]) begin
			foreach (hs[i]) begin
				col = ((hs[i] + sx[layer]) / 8) % TILE_COLS;
				off = (((vs[j] + sy[layer]) / 8) % TILE_ROWS) * TILE_COLS + col;
				val = clear ? 8'h00 : 8'(col);
				if (layer == 0) begin
					master_access(16'h0000 + 16'(off), val, 1'b1, rd);
					l0_shadow[off] = val;
				end else begin
					sub_access(16'h2000 + 16'(off), val, 1'b1, rd);
					l1_shadow[off] = val;
				end
			end
		end
	endtask

	// one whole visible frame against the model
	task automatic check_frame();
		dot_checks = 0;
		dot_arm    = 1;
		wait (dot_live);
		@(negedge clk_48m);
		while (!vblank) @(negedge clk_48m);
		dot_arm = 0;
		assert (dot_checks == TB_H_ACTIVE * TB_V_ACTIVE)
			else fail_now($sformatf("%0d dots checked in a frame", dot_checks));
	endtask

	task automatic check_irqs();
		logic [7:0] rd;
		int lead;
		master_access(16'h9000, 8'h00, 1'b1, rd);
		sub_access(16'h8000, 8'h00, 1'b1, rd);
		assert (!m_irq && !s_irq) else fail_now("irq still set after ack");
		// both rise together just ahead of the delayed vblank
		do @(negedge clk_48m); while (!m_irq);
		assert (s_irq) else fail_now("s_irq late against m_irq");
		assert (!vblank) else fail_now("irq rose after vblank");
		lead = 0;
		while (!vblank) begin
			@(negedge clk_48m);
			lead++;
		end
		assert (lead <= 2 * PIX_DIV)
			else fail_now($sformatf("irq rose %0d clocks before vblank", lead));
		// each ack clears only its own irq
		master_access(16'h9000, 8'h00, 1'b1, rd);
		assert (!m_irq && s_irq) else fail_now("master ack wrong irq state");
		sub_access(16'h8000, 8'h00, 1'b1, rd);
		assert (!m_irq && !s_irq) else fail_now("sub ack wrong irq state");
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] a;
		logic [7:0]  d;
		logic [7:0]  rd;
		logic [15:0] bases [3];
		bases = '{16'h0000, 16'h2000, 16'h4000};
		void'($urandom(32'h5fc2_1964));
		rst     = 1'b1;
		m_addr  = IDLE_ADDR;
		m_wdata = 8'h00;
		m_we    = 1'b0;
		s_addr  = IDLE_ADDR;
		s_wdata = 8'h00;
		s_we    = 1'b0;
		dot_arm = 0;
		foreach (l0_shadow[i]) begin
			l0_shadow[i] = 8'h00;
			l1_shadow[i] = 8'h00;
		end
		repeat (8) @(posedge clk_48m);
		#2;
		rst = 1'b0;
		@(negedge clk_48m);
		assert (!m_e && !s_e && !m_irq && !s_irq && dot == 8'h00)
			else fail_now("outputs not cleared by reset");

		// master writes read back by both cpus
		repeat (16) begin
			a = bases[$urandom % 3] + 16'($urandom % 8192);
			d = 8'($urandom);
			master_access(a, d, 1'b1, rd);
			master_access(a, 8'h00, 1'b0, rd);
			expect_byte(rd, d, "master");
			sub_access(a, 8'h00, 1'b0, rd);
			expect_byte(rd, d, "sub");
		end
		// sub writes read back by the master
		repeat (8) begin
			a = bases[$urandom % 3] + 16'($urandom % 8192);
			d = 8'($urandom);
			sub_access(a, d, 1'b1, rd);
			master_access(a, 8'h00, 1'b0, rd);
			expect_byte(rd, d, "master after sub write");
		end
		// io and holes read as FF
		master_access(16'h8800, 8'h00, 1'b0, rd);
		expect_byte(rd, 8'hFF, "master latch");
		sub_access(16'h6000, 8'h00, 1'b0, rd);
		expect_byte(rd, 8'hFF, "sub latch");
		master_access(IDLE_ADDR, 8'h00, 1'b0, rd);
		expect_byte(rd, 8'hFF, "master unmapped");

		check_irqs();

		// background colour and random scrolls
		bc = 8'($urandom % 255 + 1);
		master_access(16'h9400, bc, 1'b1, rd);
		sx[0] = 9'($urandom);
		sy[0] = 8'($urandom);
		sx[1] = 9'($urandom);
		sy[1] = 8'($urandom);
		master_access(16'h8800, sx[0][7:0], 1'b1, rd);
		master_access(16'h8801, {7'd0, sx[0][8]}, 1'b1, rd);
		master_access(16'h8802, sy[0], 1'b1, rd);
		sub_access(16'h6004, sx[1][7:0], 1'b1, rd);
		sub_access(16'h6005, {7'd0, sx[1][8]}, 1'b1, rd);
		sub_access(16'h6006, sy[1], 1'b1, rd);
		fork
			fill_window(0, 1'b0);
			fill_window(1, 1'b0);
		join
		check_frame();
		// layer1 shows through
		fill_window(0, 1'b1);
		check_frame();
		// only the background left
		fill_window(1, 1'b1);
		check_frame();

		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- compile.f
logic/bus_map_pkg.sv
logic/video_timing_pkg.sv
logic/video_timing.sv
logic/master_decoder.sv
logic/sub_decoder.sv
logic/bus_mux.sv
logic/video_ram.sv
logic/system86.sv
tb/system86_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := system86_tb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
